/* common/fpMul_cfg.svh */
// Format constants for the fp16 multiplier.
// Only the IEEE half-precision layout is supported. Changing these
// values alone does not retarget the datapath to another format.
`ifndef FPMUL_CFG_SVH
`define FPMUL_CFG_SVH

// Biased exponent field width.
`define FP_EXP_WIDTH 5

// Stored fraction width, hidden bit excluded.
`define FP_FRAC_WIDTH 10

// Exponent bias.
`define FP_BIAS 15

// Radix-4 steps for an 11-bit mantissa, (11 + 1) / 2.
`define MUL_ITERS 6

`endif

/* common/fpMulPkg.sv */
// Shared types for the fp16 multiplier.
// Widths come from fpMul_cfg.svh, which must be on the include path.
// The exponent sum type is signed and wider than the field so that
// underflow below zero and overflow past 31 stay visible.
`default_nettype none

`include "fpMul_cfg.svh"

package fpMulPkg;

  // One packed fp16 value: sign, exponent, fraction.
  typedef logic [`FP_EXP_WIDTH + `FP_FRAC_WIDTH:0] fpWord_t;

  // Biased exponent field.
  typedef logic [`FP_EXP_WIDTH - 1:0] expField_t;

  // Mantissa with the hidden bit in the top position.
  typedef logic [`FP_FRAC_WIDTH:0] mant_t;

  // Unsigned product of two mantissas.
  typedef logic [2 * `FP_FRAC_WIDTH + 1:0] product_t;

  // Exponent sum after removing one bias.
  typedef logic signed [`FP_EXP_WIDTH + 2:0] expSum_t;

  // Controller states.
  typedef enum logic [1:0] {
    IDLE,
    COMPUTE,
    ROUND
  } mulState_t;

endpackage

`default_nettype wire

/* rtl/fpMulControl.sv */
// Sequencer for the fp16 multiplier.
// start is a level sampled only in IDLE; a start seen in any other
// state is dropped. done is a single-cycle pulse one cycle after the
// ROUND state. The iteration count lives in the mantissa multiplier.
`timescale 1ns/10ps
`default_nettype none

module fpMulControl (
  input  logic clock,
  input  logic reset,
  input  logic start,
  input  logic iterDone,
  output logic load,
  output logic iterEn,
  output logic roundEn,
  output logic done
);

  fpMulPkg::mulState_t state;
  fpMulPkg::mulState_t nextState;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state <= fpMulPkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  // Result register is written at the same edge, so done lines up with it.
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= roundEn;
    end
  end

  always_comb begin
    nextState = state;
    load = 1'b0;
    iterEn = 1'b0;
    roundEn = 1'b0;
    case (state)
      fpMulPkg::IDLE: begin
        load = start;
        if (start) begin
          nextState = fpMulPkg::COMPUTE;
        end
      end
      fpMulPkg::COMPUTE: begin
        iterEn = 1'b1;
        // iterDone is already high during the final step.
        if (iterDone) begin
          nextState = fpMulPkg::ROUND;
        end
      end
      fpMulPkg::ROUND: begin
        roundEn = 1'b1;
        nextState = fpMulPkg::IDLE;
      end
      default: begin
        nextState = fpMulPkg::IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/fpMulUnpack.sv */
// Operand register and classifier.
// Subnormal inputs read as zero. While load is high the outputs follow
// the input operands directly, so the multiplier can capture mantB at
// the start edge. Otherwise they come from the held operands.
`timescale 1ns/10ps
`default_nettype none

`include "fpMul_cfg.svh"

module fpMulUnpack (
  input  logic              clock,
  input  logic              reset,
  input  logic              load,
  input  fpMulPkg::fpWord_t opA,
  input  fpMulPkg::fpWord_t opB,
  output fpMulPkg::mant_t   mantA,
  output fpMulPkg::mant_t   mantB,
  output fpMulPkg::expSum_t expSum,
  output logic              resultSign,
  output logic              anyNan,
  output logic              anyInf,
  output logic              anyZero
);

  localparam int FracW = `FP_FRAC_WIDTH;
  localparam int ExpW = `FP_EXP_WIDTH;

  fpMulPkg::fpWord_t opAReg;
  fpMulPkg::fpWord_t opBReg;
  fpMulPkg::fpWord_t srcA;
  fpMulPkg::fpWord_t srcB;
  fpMulPkg::expField_t expA;
  fpMulPkg::expField_t expB;
  logic zeroA;
  logic zeroB;
  logic specA;
  logic specB;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      opAReg <= '0;
      opBReg <= '0;
    end else if (load) begin
      opAReg <= opA;
      opBReg <= opB;
    end
  end

  assign srcA = load ? opA : opAReg;
  assign srcB = load ? opB : opBReg;

  assign expA = srcA[FracW +: ExpW];
  assign expB = srcB[FracW +: ExpW];

  // Exponent zero covers both true zero and subnormals.
  assign zeroA = (expA == '0);
  assign zeroB = (expB == '0);
  assign specA = (expA == '1);
  assign specB = (expB == '1);

  assign mantA = zeroA ? '0 : {1'b1, srcA[FracW - 1:0]};
  assign mantB = zeroB ? '0 : {1'b1, srcB[FracW - 1:0]};

  assign expSum = fpMulPkg::expSum_t'(expA) + fpMulPkg::expSum_t'(expB)
                - fpMulPkg::expSum_t'(`FP_BIAS);

  assign resultSign = srcA[ExpW + FracW] ^ srcB[ExpW + FracW];
  assign anyZero = zeroA | zeroB;
  assign anyInf = (specA && srcA[FracW - 1:0] == '0) || (specB && srcB[FracW - 1:0] == '0);
  assign anyNan = (specA && srcA[FracW - 1:0] != '0) || (specB && srcB[FracW - 1:0] != '0);

endmodule

`default_nettype wire

/* radix4/radix4Mantissa.sv */
// Radix-4 Booth multiplier for two 11-bit unsigned mantissas.
// load captures mantB and clears the accumulator; mantA must stay
// stable for the whole iteration phase. Six iterEn cycles finish the
// product. iterDone rises during the last step and stays high until
// the next load.
`timescale 1ns/10ps
`default_nettype none

`include "fpMul_cfg.svh"

module radix4Mantissa (
  input  logic               clock,
  input  logic               reset,
  input  logic               load,
  input  logic               iterEn,
  input  fpMulPkg::mant_t    mantA,
  input  fpMulPkg::mant_t    mantB,
  output fpMulPkg::product_t product,
  output logic               iterDone
);

  localparam int MantW = `FP_FRAC_WIDTH + 1;
  localparam int AccW = 2 * MantW + 2;
  localparam int CountW = $clog2(`MUL_ITERS + 1);

  // One zero below the LSB, two zeros above the MSB.
  logic [MantW + 2:0] multShift;
  logic [CountW - 1:0] iterCount;
  logic [CountW:0] shiftAmt;
  logic [2:0] boothBits;
  logic signed [AccW - 1:0] multiplicand;
  logic signed [AccW - 1:0] partial;
  logic signed [AccW - 1:0] acc;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      iterCount <= '0;
    end else if (load) begin
      iterCount <= '0;
    end else if (iterEn && iterCount != CountW'(`MUL_ITERS)) begin
      iterCount <= iterCount + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      multShift <= {2'b00, mantB, 1'b0};
      acc <= '0;
    end else if (iterEn) begin
      multShift <= multShift >> 2;
      acc <= acc + (partial <<< shiftAmt);
    end
  end

  assign boothBits = multShift[2:0];
  assign shiftAmt = {iterCount, 1'b0};
  assign multiplicand = $signed({{(AccW - MantW){1'b0}}, mantA});

  // Booth recoding of the current three-bit window.
  always_comb begin
    case (boothBits)
      3'b001, 3'b010: partial = multiplicand;
      3'b011:         partial = multiplicand <<< 1;
      3'b100:         partial = -(multiplicand <<< 1);
      3'b101, 3'b110: partial = -multiplicand;
      default:        partial = '0;
    endcase
  end

  // The top window always has a zero MSB, so the final sum is non-negative.
  assign product = acc[2 * MantW - 1:0];
  assign iterDone = (iterCount >= CountW'(`MUL_ITERS - 1));

endmodule

`default_nettype wire

/* rtl/fpMulRound.sv */
// Normalize, round and pack the product.
// Round to nearest even only. Results below the normal range flush to
// signed zero, no subnormal outputs. Any NaN returns the canonical
// quiet NaN with a clear sign bit. The output register loads on roundEn.
`timescale 1ns/10ps
`default_nettype none

`include "fpMul_cfg.svh"

module fpMulRound (
  input  logic               clock,
  input  logic               reset,
  input  logic               roundEn,
  input  fpMulPkg::product_t product,
  input  fpMulPkg::expSum_t  expSum,
  input  logic               resultSign,
  input  logic               anyNan,
  input  logic               anyInf,
  input  logic               anyZero,
  output fpMulPkg::fpWord_t  result
);

  localparam int FracW = `FP_FRAC_WIDTH;
  localparam int ExpW = `FP_EXP_WIDTH;
  localparam fpMulPkg::expSum_t ExpAllOnes = fpMulPkg::expSum_t'((1 << ExpW) - 1);

  fpMulPkg::product_t aligned;
  logic normHigh;
  logic [FracW - 1:0] frac;
  logic guardBit;
  logic stickyBit;
  logic roundUp;
  logic [FracW + 1:0] mantRounded;
  logic mantCarry;
  fpMulPkg::expSum_t expFinal;
  fpMulPkg::fpWord_t packedWord;
  fpMulPkg::fpWord_t infWord;
  fpMulPkg::fpWord_t zeroWord;
  fpMulPkg::fpWord_t nanWord;

  // Product lies in [1, 4). Bring the leading one to the top bit.
  assign normHigh = product[2 * FracW + 1];
  assign aligned = normHigh ? product : product << 1;

  assign frac = aligned[2 * FracW:FracW + 1];
  assign guardBit = aligned[FracW];
  assign stickyBit = |aligned[FracW - 1:0];

  // Ties go to the even fraction.
  assign roundUp = guardBit & (stickyBit | frac[0]);
  assign mantRounded = {2'b01, frac} + (FracW + 2)'(roundUp);
  assign mantCarry = mantRounded[FracW + 1];

  // On a carry the low bits are all zero, so the fraction field is right as is.
  assign expFinal = expSum + fpMulPkg::expSum_t'(normHigh)
                  + fpMulPkg::expSum_t'(mantCarry);

  assign infWord = {resultSign, {ExpW{1'b1}}, {FracW{1'b0}}};
  assign zeroWord = {resultSign, {(ExpW + FracW){1'b0}}};
  assign nanWord = {1'b0, {ExpW{1'b1}}, 1'b1, {(FracW - 1){1'b0}}};

  always_comb begin
    if (anyNan || (anyInf && anyZero)) begin
      packedWord = nanWord;
    end else if (anyInf) begin
      packedWord = infWord;
    end else if (anyZero) begin
      packedWord = zeroWord;
    end else if (expFinal >= ExpAllOnes) begin
      packedWord = infWord;
    end else if (expFinal <= fpMulPkg::expSum_t'(0)) begin
      packedWord = zeroWord;
    end else begin
      packedWord = {resultSign, expFinal[ExpW - 1:0], mantRounded[FracW - 1:0]};
    end
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      result <= '0;
    end else if (roundEn) begin
      result <= packedWord;
    end
  end

endmodule

`default_nettype wire

/* rtl/fpMulTop.sv */
// Sequential fp16 multiplier.
// A start level sampled in idle begins one operation. done pulses for
// one cycle seven cycles after the start edge, and result holds until
// the next operation completes. There is no back-pressure.
`timescale 1ns/10ps
`default_nettype none

module fpMulTop (
  input  logic              clock,
  input  logic              reset,
  input  logic              start,
  input  fpMulPkg::fpWord_t opA,
  input  fpMulPkg::fpWord_t opB,
  output fpMulPkg::fpWord_t result,
  output logic              done
);

  logic load;
  logic iterEn;
  logic roundEn;
  logic iterDone;
  fpMulPkg::mant_t mantA;
  fpMulPkg::mant_t mantB;
  fpMulPkg::expSum_t expSum;
  fpMulPkg::product_t product;
  logic resultSign;
  logic anyNan;
  logic anyInf;
  logic anyZero;

  fpMulControl fpMulControl_i (
    .clock   (clock),
    .reset   (reset),
    .start   (start),
    .iterDone(iterDone),
    .load    (load),
    .iterEn  (iterEn),
    .roundEn (roundEn),
    .done    (done)
  );

  fpMulUnpack fpMulUnpack_i (
    .clock     (clock),
    .reset     (reset),
    .load      (load),
    .opA       (opA),
    .opB       (opB),
    .mantA     (mantA),
    .mantB     (mantB),
    .expSum    (expSum),
    .resultSign(resultSign),
    .anyNan    (anyNan),
    .anyInf    (anyInf),
    .anyZero   (anyZero)
  );

  radix4Mantissa radix4Mantissa_i (
    .clock   (clock),
    .reset   (reset),
    .load    (load),
    .iterEn  (iterEn),
    .mantA   (mantA),
    .mantB   (mantB),
    .product (product),
    .iterDone(iterDone)
  );

  fpMulRound fpMulRound_i (
    .clock     (clock),
    .reset     (reset),
    .roundEn   (roundEn),
    .product   (product),
    .expSum    (expSum),
    .resultSign(resultSign),
    .anyNan    (anyNan),
    .anyInf    (anyInf),
    .anyZero   (anyZero),
    .result    (result)
  );

endmodule

`default_nettype wire

/* test/fpMulModel.svh */
// Reference model and random source for the fp16 multiplier testbench.
// The model works on plain integers. Subnormal inputs count as zero,
// results below the normal range flush to signed zero, and overflow
// gives signed infinity. Any NaN case returns 16'h7E00.
`ifndef FPMUL_MODEL_SVH
`define FPMUL_MODEL_SVH

function automatic logic [15:0] expectedProduct(input logic [15:0] a, input logic [15:0] b);
  int expA;
  int expB;
  int expOut;
  int prod;
  int shift;
  int mant;
  int rest;
  int half;
  logic sign;
  logic nanIn;
  logic infA;
  logic infB;
  logic zeroA;
  logic zeroB;
  sign = a[15] ^ b[15];
  expA = int'(a[14:10]);
  expB = int'(b[14:10]);
  zeroA = (expA == 0);
  zeroB = (expB == 0);
  infA = (expA == 31) && (a[9:0] == 10'd0);
  infB = (expB == 31) && (b[9:0] == 10'd0);
  nanIn = (expA == 31 && a[9:0] != 10'd0) || (expB == 31 && b[9:0] != 10'd0);
  if (nanIn || (infA && zeroB) || (infB && zeroA)) return 16'h7E00;
  if (infA || infB) return {sign, 15'h7C00};
  if (zeroA || zeroB) return {sign, 15'h0000};
  // Both significands lie in [1, 2), so the product lies in [1, 4).
  prod = (1024 + int'(a[9:0])) * (1024 + int'(b[9:0]));
  expOut = expA + expB - 15;
  shift = 10;
  if (prod >= (1 << 21)) begin
    shift = 11;
    expOut = expOut + 1;
  end
  mant = prod >> shift;
  rest = prod - (mant << shift);
  half = 1 << (shift - 1);
  // Nearest value, ties to an even significand.
  if (rest > half || (rest == half && mant % 2 == 1)) mant = mant + 1;
  if (mant == 2048) begin
    mant = 1024;
    expOut = expOut + 1;
  end
  if (expOut >= 31) return {sign, 15'h7C00};
  if (expOut <= 0) return {sign, 15'h0000};
  return {sign, expOut[4:0], mant[9:0]};
endfunction

// Fibonacci LFSR, taps 32, 22, 2 and 1. The new bit enters at bit 0.
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
  logic feedback;
  feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], feedback};
endfunction

`endif

/* test/fpMulTb.sv */
// Testbench for the fp16 multiplier.
// Directed, special-value, busy-start and 400 random operations.
// Assertions compare done timing and result against the integer model.
// The run stops at the first failing check.
`timescale 1ns/10ps
`default_nettype none

module fpMulTb;

  `include "fpMulModel.svh"

  localparam int DirectedCount = 23;
  localparam int RandomCount = 400;
  localparam int TimeoutCycles = (DirectedCount + 1 + RandomCount) * 12 + 100;
  // Each entry holds opA in the upper half and opB in the lower half.
  // The last three hit a rounding carry and both tie cases.
  localparam logic [31:0] DirectedOps [DirectedCount] = '{
    32'h3C00_3C00, 32'h3E00_4000, 32'h3FFF_3FFF, 32'hBFFF_3FFF, 32'h7E01_3C00,
    32'h3C00_FC01, 32'h7C01_7C00, 32'h7C00_0000, 32'h0000_FC00, 32'h7C00_4000,
    32'hFC00_3E00, 32'h0000_4200, 32'h8000_3C00, 32'h0200_4000, 32'h0001_8001,
    32'h7BFF_7BFF, 32'hFBFF_4000, 32'h0400_0400, 32'h8400_3800, 32'h7BFF_3C01,
    32'h3DA8_3DA8, 32'h3C01_3E00, 32'h3C03_3E00
  };

  logic clock = 1'b0;
  logic reset;
  logic start;
  logic [15:0] opA;
  logic [15:0] opB;
  logic [15:0] result;
  logic done;
  logic [31:0] lfsrState = 32'h4733;
  logic pending;
  int age;
  int cycleCount = 0;
  logic [15:0] expectedResult;
  logic [15:0] resultPrev;
  logic doneExpected;
  logic [15:0] opAQueue[$];
  logic [15:0] opBQueue[$];

  fpMulTop fpMulTop_i (
    .clock (clock),
    .reset (reset),
    .start (start),
    .opA   (opA),
    .opB   (opB),
    .result(result),
    .done  (done)
  );

  always #20 clock = ~clock;

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  // Accepted starts as the DUT should see them; edge 0 sets age to 0.
  always @(posedge clock or posedge reset) begin
    if (reset) begin
      pending <= 1'b0;
      age <= 0;
      expectedResult <= '0;
      resultPrev <= '0;
      opAQueue.delete();
      opBQueue.delete();
    end else begin
      resultPrev <= result;
      if (pending && age == 6) begin
        expectedResult <= expectedProduct(opAQueue.pop_front(), opBQueue.pop_front());
      end
      if ((!pending || age == 7) && start) begin
        pending <= 1'b1;
        age <= 0;
        opAQueue.push_back(opA);
        opBQueue.push_back(opB);
      end else if (pending && age == 7) begin
        pending <= 1'b0;
      end else if (pending) begin
        age <= age + 1;
      end
    end
  end

  assign doneExpected = pending && (age == 7);

  doneTiming: assert property (@(posedge clock) disable iff (reset) done == doneExpected)
    else failRun($sformatf("MISMATCH done expected %h actual %h",
                           $sampled(doneExpected), $sampled(done)));

  resultMatchesModel: assert property (@(posedge clock) disable iff (reset)
                                       result == expectedResult)
    else failRun($sformatf("MISMATCH result expected %h actual %h",
                           $sampled(expectedResult), $sampled(result)));

  resultHolds: assert property (@(posedge clock) disable iff (reset) !done |-> result == resultPrev)
    else failRun($sformatf("MISMATCH result expected %h actual %h while done low",
                           $sampled(resultPrev), $sampled(result)));

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      failRun($sformatf("timeout, no end of test after %0d cycles", TimeoutCycles));
    end
  end

  task automatic drawBits(input int count, output logic [15:0] value);
    value = '0;
    for (int n = 0; n < count; n++) begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[14:0], lfsrState[0]};
    end
  endtask

  // Exponent limited to 1..30 so the operand is always normal.
  task automatic randomNormal(output logic [15:0] word);
    logic [15:0] signBit;
    logic [15:0] expRaw;
    logic [15:0] frac;
    drawBits(1, signBit);
    drawBits(5, expRaw);
    drawBits(10, frac);
    word = {signBit[0], 5'((expRaw % 30) + 1), frac[9:0]};
  endtask

  task automatic nextCycle();
    @(posedge clock);
    #2;
  endtask

  // Called 2 ns after a rising edge; returns in the cycle where done is high.
  task automatic runOp(input logic [15:0] a, input logic [15:0] b);
    start = 1'b1;
    opA = a;
    opB = b;
    nextCycle();
    start = 1'b0;
    while (done !== 1'b1) begin
      nextCycle();
    end
  endtask

  initial begin
    logic [15:0] a;
    logic [15:0] b;
    reset = 1'b1;
    start = 1'b0;
    opA = '0;
    opB = '0;
    repeat (16) @(posedge clock);
    #2;
    reset = 1'b0;
    repeat (2) nextCycle();
    for (int i = 0; i < DirectedCount; i++) begin
      runOp(DirectedOps[i][31:16], DirectedOps[i][15:0]);
    end
    // Idle cycles with moving operands, result must hold.
    for (int i = 0; i < 5; i++) begin
      drawBits(16, a);
      drawBits(16, b);
      opA = a;
      opB = b;
      nextCycle();
    end
    // Start held high while busy, operands changing after the start edge.
    start = 1'b1;
    opA = 16'h4500;
    opB = 16'hC200;
    nextCycle();
    for (int i = 0; i < 3; i++) begin
      drawBits(16, a);
      drawBits(16, b);
      opA = a;
      opB = b;
      nextCycle();
    end
    start = 1'b0;
    while (done !== 1'b1) begin
      nextCycle();
    end
    for (int i = 0; i < RandomCount; i++) begin
      randomNormal(a);
      randomNormal(b);
      runOp(a, b);
    end
    repeat (4) nextCycle();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
+incdir+test
common/fpMulPkg.sv
rtl/fpMulControl.sv
rtl/fpMulUnpack.sv
radix4/radix4Mantissa.sv
rtl/fpMulRound.sv
rtl/fpMulTop.sv
test/fpMulTb.sv

/* run.sh */
#!/bin/sh
# Build and run the fp16 multiplier testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal --top-module fpMulTb \
  -f project.f -o fpMulSim

./obj_dir/fpMulSim | tee sim.log

if grep -q "^test passed$" sim.log; then
  exit 0
else
  exit 1
fi
